// ==== ctrlport_subsys.f ====
+incdir+src
src/ctrlport_pkg.sv
src/ctrlport_req_tracker.sv
src/ctrlport_reg_bank.sv
src/ctrlport_resp_combiner.sv
src/ctrlport_subsys.sv
verif/tb_ctrlport_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the control-port subsystem testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f ctrlport_subsys.f \
  --top-module tb_ctrlport_subsys \
  -o tb_ctrlport_subsys
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_ctrlport_subsys)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// ==== src/ctrlport_params.svh ====
// Control-port subsystem parameters
// Bus widths, bank count, bank window span and request timeout

`ifndef CTRLPORT_PARAMS_SVH
`define CTRLPORT_PARAMS_SVH

//------------------------------------------------------------
// Bus widths
//------------------------------------------------------------
// Byte address width of the control-port request
`define CTRLPORT_ADDR_W 20
// Width of write and read data words
`define CTRLPORT_DATA_W 32
// One byte enable per data byte
`define CTRLPORT_BE_W (`CTRLPORT_DATA_W / 8)

//------------------------------------------------------------
// Address map and timing
//------------------------------------------------------------
// Number of register banks hanging off the request broadcast
`define CTRLPORT_NUM_BANKS 4
// Size of each bank window in bytes, bank i starts at i times this value
`define CTRLPORT_BANK_SPAN 16
// Cycles to wait for a bank ack before answering with an error
`define CTRLPORT_TIMEOUT 8

`endif

// ==== src/ctrlport_pkg.sv ====
// Control-port package
// Response status encoding shared by tracker, banks, combiner and top level

`default_nettype none

package ctrlport_pkg;

  // Status returned with every ack
  // The encodings follow the usual control-port response codes
  typedef enum logic [1:0] {
    // Access completed normally
    sts_okay   = 2'd0,
    // Command not allowed at this address, e.g. a write to a read-only word
    sts_cmderr = 2'd1,
    // Timestamp error, reserved here and never produced
    sts_tserr  = 2'd2,
    // No slave answered the request
    sts_slverr = 2'd3
  } ctrlport_status_t;

endpackage

`default_nettype wire

// ==== src/ctrlport_reg_bank.sv ====
// Control-port register bank
// Three byte-writable registers and a read-only ID word inside one
// address window selected by the bank index

`timescale 1ns/1ps
`default_nettype none
`include "ctrlport_params.svh"

module ctrlport_reg_bank #(
  parameter int bank_index = 0
) (
  input  wire logic                          s_ctrlport,
  input  wire logic                          arst_n,
  // Broadcast request from the tracker
  input  wire logic                          bank_req_wr,
  input  wire logic                          bank_req_rd,
  input  wire logic [`CTRLPORT_ADDR_W-1:0]   bank_req_addr,
  input  wire logic [`CTRLPORT_DATA_W-1:0]   bank_req_data,
  input  wire logic [`CTRLPORT_BE_W-1:0]     bank_req_byte_en,
  // Response, only meaningful while ack is high
  output logic                               ack,
  output ctrlport_pkg::ctrlport_status_t     status,
  output logic      [`CTRLPORT_DATA_W-1:0]   data
);

  import ctrlport_pkg::*;

  // Low address bits that select a byte inside the window
  localparam int span_lsb = $clog2(`CTRLPORT_BANK_SPAN);
  localparam int num_regs = 3;
  // Identification word read back at offset 12
  localparam logic [`CTRLPORT_DATA_W-1:0] id_word =
    32'hB0A0_0000 + `CTRLPORT_DATA_W'(bank_index);

  logic [`CTRLPORT_DATA_W-1:0] regs [num_regs];
  logic [`CTRLPORT_DATA_W-1:0] rd_word;
  logic [span_lsb-3:0]         word_idx;
  logic                        in_window;
  logic                        hit;
  logic                        is_id;

  //------------------------------------------------------------
  // Address decode
  //------------------------------------------------------------
  // Upper address bits must equal the bank index for this bank to answer
  assign in_window = bank_req_addr[`CTRLPORT_ADDR_W-1:span_lsb] ==
                     (`CTRLPORT_ADDR_W - span_lsb)'(bank_index);
  assign hit       = in_window && (bank_req_wr || bank_req_rd);
  // Word offset inside the window, byte lane bits are ignored
  assign word_idx  = bank_req_addr[span_lsb-1:2];
  // The last word of the window is the ID word
  assign is_id     = (word_idx == '1);

  // Read mux over the writable registers and the ID word
  always_comb begin
    case (word_idx)
      2'd0:    rd_word = regs[0];
      2'd1:    rd_word = regs[1];
      2'd2:    rd_word = regs[2];
      default: rd_word = id_word;
    endcase
  end

  //------------------------------------------------------------
  // Registers and ack
  //------------------------------------------------------------
  // Writes update only the enabled byte lanes of the addressed register
  always_ff @(posedge s_ctrlport or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
      for (int r = 0; r < num_regs; r++) begin
        regs[r] <= '0;
      end
    end else begin
      ack <= hit;
      for (int r = 0; r < num_regs; r++) begin
        if (hit && bank_req_wr && word_idx == 2'(r)) begin
          for (int b = 0; b < `CTRLPORT_BE_W; b++) begin
            if (bank_req_byte_en[b]) begin
              regs[r][8*b +: 8] <= bank_req_data[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // Writes to the ID word are refused, reads return data and writes return zero
  always_ff @(posedge s_ctrlport) begin
    if (hit) begin
      status <= (bank_req_wr && is_id) ? sts_cmderr : sts_okay;
      data   <= bank_req_rd ? rd_word : '0;
    end
  end

  // Every request strobe lasts one cycle, so neither does any ack
  a_ack_single_cycle: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    ack |=> !ack
  );

endmodule

`default_nettype wire

// ==== src/ctrlport_req_tracker.sv ====
// Control-port request tracker
// Registers each master request and broadcasts it to all banks,
// then times out requests that no bank acknowledges

`timescale 1ns/1ps
`default_nettype none
`include "ctrlport_params.svh"

module ctrlport_req_tracker (
  input  wire logic                          s_ctrlport,
  input  wire logic                          arst_n,
  // Master request strobes and payload
  input  wire logic                          req_wr,
  input  wire logic                          req_rd,
  input  wire logic [`CTRLPORT_ADDR_W-1:0]   req_addr,
  input  wire logic [`CTRLPORT_DATA_W-1:0]   req_data,
  input  wire logic [`CTRLPORT_BE_W-1:0]     req_byte_en,
  // Registered response seen by the master, closes the request
  input  wire logic                          resp_ack,
  // Broadcast to every bank
  output logic                               bank_req_wr,
  output logic                               bank_req_rd,
  output logic      [`CTRLPORT_ADDR_W-1:0]   bank_req_addr,
  output logic      [`CTRLPORT_DATA_W-1:0]   bank_req_data,
  output logic      [`CTRLPORT_BE_W-1:0]     bank_req_byte_en,
  // Error response injected when no bank answers in time
  output logic                               timeout_ack,
  output ctrlport_pkg::ctrlport_status_t     timeout_status
);

  import ctrlport_pkg::*;

  // Counter must hold TIMEOUT+1, the value it reaches while resp_ack is in flight
  localparam int cnt_w = $clog2(`CTRLPORT_TIMEOUT + 2);

  logic             busy;
  logic [cnt_w-1:0] cycle_cnt;
  logic             req_strobe;

  assign req_strobe = req_wr | req_rd;

  //------------------------------------------------------------
  // Request broadcast
  //------------------------------------------------------------
  // Payload is captured on the strobe and only looked at while a strobe is out
  always_ff @(posedge s_ctrlport) begin
    if (req_strobe) begin
      bank_req_addr    <= req_addr;
      bank_req_data    <= req_data;
      bank_req_byte_en <= req_byte_en;
    end
  end

  // Strobes are delayed by one cycle so the banks see them with the payload
  // The count restarts at zero in the cycle the banks receive the request
  always_ff @(posedge s_ctrlport or negedge arst_n) begin
    if (!arst_n) begin
      bank_req_wr <= 1'b0;
      bank_req_rd <= 1'b0;
      busy        <= 1'b0;
      cycle_cnt   <= '0;
    end else begin
      bank_req_wr <= req_wr;
      bank_req_rd <= req_rd;
      if (req_strobe) begin
        busy      <= 1'b1;
        cycle_cnt <= '0;
      end else if (resp_ack) begin
        busy      <= 1'b0;
        cycle_cnt <= '0;
      end else if (busy && cycle_cnt <= cnt_w'(`CTRLPORT_TIMEOUT)) begin
        cycle_cnt <= cycle_cnt + cnt_w'(1);
      end
    end
  end

  //------------------------------------------------------------
  // Timeout response
  //------------------------------------------------------------
  // One-cycle pulse, the combiner adds one more cycle so the master sees
  // the error TIMEOUT+2 cycles after its strobe
  assign timeout_ack    = busy && (cycle_cnt == cnt_w'(`CTRLPORT_TIMEOUT));
  assign timeout_status = timeout_ack ? sts_slverr : sts_okay;

  // The master must hold off until the previous response has come back
  a_no_strobe_while_busy: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    req_strobe |-> (!busy || resp_ack)
  );

  // A request is either a write or a read, never both
  a_single_strobe: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    !(req_wr && req_rd)
  );

endmodule

`default_nettype wire

// ==== src/ctrlport_resp_combiner.sv ====
// Control-port response combiner
// Masks every bank response and the timeout response with its own ack,
// ORs them together and registers the result for the master

`timescale 1ns/1ps
`default_nettype none
`include "ctrlport_params.svh"

module ctrlport_resp_combiner (
  input  wire logic                                                s_ctrlport,
  input  wire logic                                                arst_n,
  // Responses of all banks
  input  wire logic [`CTRLPORT_NUM_BANKS-1:0]                      bank_ack,
  input  var  ctrlport_pkg::ctrlport_status_t [`CTRLPORT_NUM_BANKS-1:0] bank_status,
  input  wire logic [`CTRLPORT_NUM_BANKS-1:0][`CTRLPORT_DATA_W-1:0] bank_data,
  // Error response from the tracker, it always carries zero data
  input  wire logic                                                timeout_ack,
  input  var  ctrlport_pkg::ctrlport_status_t                      timeout_status,
  // Registered response to the master
  output logic                                                     resp_ack,
  output ctrlport_pkg::ctrlport_status_t                           resp_status,
  output logic      [`CTRLPORT_DATA_W-1:0]                         resp_data
);

  import ctrlport_pkg::*;

  logic                            comb_ack;
  logic [$bits(ctrlport_status_t)-1:0] comb_status;
  logic [`CTRLPORT_DATA_W-1:0]     comb_data;

  // Sources that did not ack contribute all zeros to the OR
  always_comb begin
    comb_ack    = timeout_ack;
    comb_status = timeout_ack ? timeout_status : '0;
    comb_data   = '0;
    for (int i = 0; i < `CTRLPORT_NUM_BANKS; i++) begin
      comb_ack    = comb_ack | bank_ack[i];
      comb_status = comb_status | (bank_ack[i] ? bank_status[i] : '0);
      comb_data   = comb_data | (bank_ack[i] ? bank_data[i] : '0);
    end
  end

  // Output register breaks the path from the bank decoders to the master
  always_ff @(posedge s_ctrlport or negedge arst_n) begin
    if (!arst_n) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= comb_ack;
    end
  end

  always_ff @(posedge s_ctrlport) begin
    resp_status <= ctrlport_status_t'(comb_status);
    resp_data   <= comb_data;
  end

  // The OR is only a valid merge while a single source answers
  a_one_source: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    $onehot0({timeout_ack, bank_ack})
  );

endmodule

`default_nettype wire

// ==== src/ctrlport_subsys.sv ====
// Control-port register subsystem top level
// Request tracker, a generated row of register banks and the response combiner

`timescale 1ns/1ps
`default_nettype none
`include "ctrlport_params.svh"

module ctrlport_subsys (
  input  wire logic                          s_ctrlport,
  input  wire logic                          arst_n,
  // Master request
  input  wire logic                          req_wr,
  input  wire logic                          req_rd,
  input  wire logic [`CTRLPORT_ADDR_W-1:0]   req_addr,
  input  wire logic [`CTRLPORT_DATA_W-1:0]   req_data,
  input  wire logic [`CTRLPORT_BE_W-1:0]     req_byte_en,
  // Master response
  output logic                               resp_ack,
  output ctrlport_pkg::ctrlport_status_t     resp_status,
  output logic      [`CTRLPORT_DATA_W-1:0]   resp_data
);

  import ctrlport_pkg::*;

  // Request broadcast from the tracker to every bank
  logic                        bank_req_wr;
  logic                        bank_req_rd;
  logic [`CTRLPORT_ADDR_W-1:0] bank_req_addr;
  logic [`CTRLPORT_DATA_W-1:0] bank_req_data;
  logic [`CTRLPORT_BE_W-1:0]   bank_req_byte_en;

  // One response slot per bank plus the timeout source
  logic [`CTRLPORT_NUM_BANKS-1:0]                       bank_ack;
  ctrlport_status_t [`CTRLPORT_NUM_BANKS-1:0]           bank_status;
  logic [`CTRLPORT_NUM_BANKS-1:0][`CTRLPORT_DATA_W-1:0] bank_data;
  logic                                                 timeout_ack;
  ctrlport_status_t                                     timeout_status;

  ctrlport_req_tracker u_req_tracker (
    .s_ctrlport       (s_ctrlport),
    .arst_n           (arst_n),
    .req_wr           (req_wr),
    .req_rd           (req_rd),
    .req_addr         (req_addr),
    .req_data         (req_data),
    .req_byte_en      (req_byte_en),
    .resp_ack         (resp_ack),
    .bank_req_wr      (bank_req_wr),
    .bank_req_rd      (bank_req_rd),
    .bank_req_addr    (bank_req_addr),
    .bank_req_data    (bank_req_data),
    .bank_req_byte_en (bank_req_byte_en),
    .timeout_ack      (timeout_ack),
    .timeout_status   (timeout_status)
  );

  // Each bank decodes its own window, so all of them see the same request
  for (genvar i = 0; i < `CTRLPORT_NUM_BANKS; i++) begin : gen_bank
    ctrlport_reg_bank #(
      .bank_index (i)
    ) u_reg_bank (
      .s_ctrlport       (s_ctrlport),
      .arst_n           (arst_n),
      .bank_req_wr      (bank_req_wr),
      .bank_req_rd      (bank_req_rd),
      .bank_req_addr    (bank_req_addr),
      .bank_req_data    (bank_req_data),
      .bank_req_byte_en (bank_req_byte_en),
      .ack              (bank_ack[i]),
      .status           (bank_status[i]),
      .data             (bank_data[i])
    );
  end

  ctrlport_resp_combiner u_resp_combiner (
    .s_ctrlport     (s_ctrlport),
    .arst_n         (arst_n),
    .bank_ack       (bank_ack),
    .bank_status    (bank_status),
    .bank_data      (bank_data),
    .timeout_ack    (timeout_ack),
    .timeout_status (timeout_status),
    .resp_ack       (resp_ack),
    .resp_status    (resp_status),
    .resp_data      (resp_data)
  );

endmodule

`default_nettype wire

// ==== verif/tb_ctrlport_subsys.sv ====
// Testbench for the control-port register subsystem
// Clock, reset, bus stimulus, latency and response assertions, watchdog

`timescale 1ns/1ps
`default_nettype none
`include "ctrlport_params.svh"

module tb_ctrlport_subsys;

  import ctrlport_pkg::*;

  localparam int clk_period = 40;
  localparam int num_regs = 3;
  localparam int map_size = `CTRLPORT_NUM_BANKS * `CTRLPORT_BANK_SPAN;
  // One cycle in the tracker, the timeout window and one cycle in the combiner
  localparam int unmapped_lat = `CTRLPORT_TIMEOUT + 2;
  // Accesses issued by all tests together
  localparam int max_accesses = (5 * num_regs + 3) * `CTRLPORT_NUM_BANKS + 3;
  localparam int watchdog_cycles = max_accesses * (`CTRLPORT_TIMEOUT + 10);

  logic                        s_ctrlport;
  logic                        arst_n;
  logic                        req_wr;
  logic                        req_rd;
  logic [`CTRLPORT_ADDR_W-1:0] req_addr;
  logic [`CTRLPORT_DATA_W-1:0] req_data;
  logic [`CTRLPORT_BE_W-1:0]   req_byte_en;
  logic                        resp_ack;
  ctrlport_status_t            resp_status;
  logic [`CTRLPORT_DATA_W-1:0] resp_data;
  logic                        req_strobe;
  logic                        req_mapped;

  // Mirror of every writable register
  logic [`CTRLPORT_DATA_W-1:0] sb [`CTRLPORT_NUM_BANKS][num_regs];
  integer                      seed;
  int                          error_count;
  int                          tests_run;
  int                          tests_failed;
  int                          errors_before;
  logic [`CTRLPORT_DATA_W-1:0] wdata;
  logic [`CTRLPORT_BE_W-1:0]   be;

  ctrlport_subsys u_ctrlport_subsys (
    .s_ctrlport  (s_ctrlport),
    .arst_n      (arst_n),
    .req_wr      (req_wr),
    .req_rd      (req_rd),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .req_byte_en (req_byte_en),
    .resp_ack    (resp_ack),
    .resp_status (resp_status),
    .resp_data   (resp_data)
  );

  always #(clk_period / 2) s_ctrlport = ~s_ctrlport;

  assign req_strobe = req_wr | req_rd;
  assign req_mapped = req_addr < `CTRLPORT_ADDR_W'(map_size);

  //------------------------------------------------------------
  // Latency checks
  //------------------------------------------------------------
  // The response is a single pulse, so a hit on the exact cycle also rules out early acks
  a_mapped_latency: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    (req_strobe && req_mapped) |-> ##3 resp_ack
  ) else begin
    error_count++;
    $display("error at %0t: no resp_ack 3 cycles after a mapped strobe", $time);
  end

  a_unmapped_latency: assert property (
    @(posedge s_ctrlport) disable iff (!arst_n)
    (req_strobe && !req_mapped) |-> ##unmapped_lat resp_ack
  ) else begin
    error_count++;
    $display("error at %0t: no timeout resp_ack after an unmapped strobe", $time);
  end

  // Byte address of a register word inside a bank window
  function automatic logic [`CTRLPORT_ADDR_W-1:0] bank_addr(input int bank, input int word);
    return `CTRLPORT_ADDR_W'(bank * `CTRLPORT_BANK_SPAN + 4 * word);
  endfunction

  // Enabled byte lanes take the new data, the others keep the old value
  function automatic logic [`CTRLPORT_DATA_W-1:0] merge_bytes(
    input logic [`CTRLPORT_DATA_W-1:0] old_word,
    input logic [`CTRLPORT_DATA_W-1:0] new_word,
    input logic [`CTRLPORT_BE_W-1:0]   lanes
  );
    logic [`CTRLPORT_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `CTRLPORT_BE_W; b++) begin
      if (lanes[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  // One strobe, then wait for the response and check it, read data only on reads
  task automatic run_access(
    input logic                        wr,
    input logic [`CTRLPORT_ADDR_W-1:0] addr,
    input logic [`CTRLPORT_DATA_W-1:0] data,
    input logic [`CTRLPORT_BE_W-1:0]   lanes,
    input ctrlport_status_t            exp_status,
    input logic [`CTRLPORT_DATA_W-1:0] exp_data
  );
    int waited;
    waited = 0;
    @(posedge s_ctrlport);
    #2;
    req_wr      = wr;
    req_rd      = !wr;
    req_addr    = addr;
    req_data    = data;
    req_byte_en = lanes;
    @(posedge s_ctrlport);
    #2;
    req_wr = 1'b0;
    req_rd = 1'b0;
    @(negedge s_ctrlport);
    while (!resp_ack && waited < `CTRLPORT_TIMEOUT + 10) begin
      waited++;
      @(negedge s_ctrlport);
    end
    if (!resp_ack) begin
      error_count++;
      $display("access to address %h never got a response", addr);
    end else begin
      assert (resp_status == exp_status) else begin
        error_count++;
        $display("error at %0t: address %h status %0d, expected %0d",
                 $time, addr, resp_status, exp_status);
      end
      assert (wr || resp_data == exp_data) else begin
        error_count++;
        $display("error at %0t: address %h read %h, expected %h",
                 $time, addr, resp_data, exp_data);
      end
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %-22s ok", name);
    end else begin
      tests_failed++;
      $display("test %-22s FAILED with %0d errors", name, error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  // Watchdog sized for the longest possible run of all accesses
  initial begin
    #(watchdog_cycles * clk_period);
    $display("simulation timed out before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    s_ctrlport = 1'b0;
    arst_n = 1'b0;
    req_wr = 1'b0;
    req_rd = 1'b0;
    req_addr = '0;
    req_data = '0;
    req_byte_en = '0;
    seed = 32'h1397;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_before = 0;
    repeat (4) @(posedge s_ctrlport);
    #2;
    arst_n = 1'b1;

    // After reset
    assert (!resp_ack) else begin
      error_count++;
      $display("error at %0t: resp_ack high right after reset", $time);
    end
    for (int b = 0; b < `CTRLPORT_NUM_BANKS; b++) begin
      for (int r = 0; r < num_regs; r++) begin
        sb[b][r] = '0;
        run_access(1'b0, bank_addr(b, r), '0, '1, sts_okay, '0);
      end
    end
    close_test("reset values");

    // Full-word write and read back
    for (int b = 0; b < `CTRLPORT_NUM_BANKS; b++) begin
      for (int r = 0; r < num_regs; r++) begin
        wdata = $random(seed);
        run_access(1'b1, bank_addr(b, r), wdata, '1, sts_okay, '0);
        sb[b][r] = wdata;
        run_access(1'b0, bank_addr(b, r), '0, '1, sts_okay, sb[b][r]);
      end
    end
    close_test("full write readback");

    // Partial byte enables
    for (int b = 0; b < `CTRLPORT_NUM_BANKS; b++) begin
      for (int r = 0; r < num_regs; r++) begin
        wdata = $random(seed);
        be = `CTRLPORT_BE_W'($random(seed));
        if (be == '1) be = `CTRLPORT_BE_W'(6);
        run_access(1'b1, bank_addr(b, r), wdata, be, sts_okay, '0);
        sb[b][r] = merge_bytes(sb[b][r], wdata, be);
        run_access(1'b0, bank_addr(b, r), '0, '1, sts_okay, sb[b][r]);
      end
    end
    close_test("partial byte enables");

    // Read-only ID word at offset 12
    for (int b = 0; b < `CTRLPORT_NUM_BANKS; b++) begin
      wdata = 32'hB0A0_0000 + 32'(b);
      run_access(1'b0, bank_addr(b, 3), '0, '1, sts_okay, wdata);
      run_access(1'b1, bank_addr(b, 3), 32'hFFFF_FFFF, '1, sts_cmderr, '0);
      run_access(1'b0, bank_addr(b, 3), '0, '1, sts_okay, wdata);
    end
    close_test("id word");

    // Unmapped addresses time out, then a mapped read must still work
    run_access(1'b1, `CTRLPORT_ADDR_W'(map_size), $random(seed), '1, sts_slverr, '0);
    run_access(1'b0, `CTRLPORT_ADDR_W'('hFFF00), '0, '1, sts_slverr, '0);
    run_access(1'b0, bank_addr(`CTRLPORT_NUM_BANKS - 1, 2), '0, '1, sts_okay,
               sb[`CTRLPORT_NUM_BANKS - 1][2]);
    close_test("unmapped timeout");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
